//--- cdw_pkg.sv
// Context directory walker package
package cdw_pkg;

    localparam int DID_W    = 24;
    localparam int PPN_W    = 44;
    localparam int PLEN     = 56;
    localparam int DW_W     = 64;
    localparam int DC_WORDS = 4;
    localparam int CAUSE_W  = 12;

    // Beat index and beat counter widths
    localparam int IDX_W    = $clog2(DC_WORDS);
    localparam int CNT_W    = $clog2(DC_WORDS + 1);

    // Non-leaf entry layout
    localparam int NL_V_BIT   = 0;
    localparam int NL_PPN_LSB = 10;
    localparam int NL_PPN_MSB = 53;
    localparam logic [DW_W-1:0] NL_RSVD_MASK = 64'hFFC0_0000_0000_03FE;

    // Device context word layout
    localparam int TC_V_BIT      = 0;
    localparam int TC_EN_ATS_BIT = 1;
    localparam int TC_T2GPA_BIT  = 2;
    localparam logic [DW_W-1:0] TC_RSVD_MASK = 64'hFFFF_FFFF_0000_0000;
    localparam logic [DW_W-1:0] TA_RSVD_MASK = 64'hFFF0_0000_0000_0FFF;
    localparam int MODE_LSB = 60;
    localparam int MODE_W   = 4;

    localparam logic [MODE_W-1:0] MODE_BARE = 4'd0;
    localparam logic [MODE_W-1:0] MODE_SV39 = 4'd8;
    localparam logic [MODE_W-1:0] MODE_SV48 = 4'd9;

    // Word order inside the device context burst
    localparam logic [IDX_W-1:0] DC_TC      = 2'd0;
    localparam logic [IDX_W-1:0] DC_IOHGATP = 2'd1;
    localparam logic [IDX_W-1:0] DC_TA      = 2'd2;
    localparam logic [IDX_W-1:0] DC_FSC     = 2'd3;

    typedef enum logic [1:0] {
        DDT_1LVL = 2'd0,
        DDT_2LVL = 2'd1,
        DDT_3LVL = 2'd2
    } ddt_mode_e;

    typedef enum logic [CAUSE_W-1:0] {
        CAUSE_DDT_INVALID = 12'd258,
        CAUSE_DDT_MISCONF = 12'd259,
        CAUSE_DDT_CORRUPT = 12'd268
    } cause_e;

    typedef struct packed {
        logic t2gpa;
        logic sv39;
        logic sv48;
        logic svx4;    // Sv39x4 and Sv48x4 for iohgatp
    } caps_t;

    typedef struct packed {
        logic            ar_valid;
        logic [PLEN-1:0] ar_addr;
        logic            ar_burst;    // High for a full context burst
        logic            r_ready;
    } mem_req_t;

    typedef struct packed {
        logic            ar_ready;
        logic            r_valid;
        logic [DW_W-1:0] r_data;
        logic            r_last;
        logic            r_err;
    } mem_rsp_t;

    typedef struct packed {
        logic [DW_W-1:0] tc;
        logic [DW_W-1:0] iohgatp;
        logic [DW_W-1:0] ta;
        logic [DW_W-1:0] fsc;
    } dc_t;

    typedef struct packed {
        logic             take;
        logic             leaf;
        logic [IDX_W-1:0] idx;
    } beat_t;

endpackage

//--- cdw_ctrl.sv
`timescale 1ns/1ps
// Walker control FSM
module cdw_ctrl (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                start_i,
    input  cdw_pkg::ddt_mode_e  ddtp_mode_i,
    input  cdw_pkg::mem_rsp_t   mem_rsp_i,
    input  logic                entry_invalid_i,
    input  logic                entry_misconf_i,
    output logic                ar_valid_o,
    output logic                ar_burst_o,
    output logic                r_ready_o,
    output logic                busy_o,
    output logic                load_root_o,
    output logic                step_o,
    output cdw_pkg::ddt_mode_e  level_o,
    output cdw_pkg::beat_t      beat_o,
    output logic                update_o,
    output logic                error_o,
    output cdw_pkg::cause_e     cause_o
);

    typedef enum logic [2:0] {
        IDLE,
        MEM_ACCESS,
        NON_LEAF,
        LEAF,
        ERROR
    } state_e;

    state_e                      state_q, state_n;
    cdw_pkg::ddt_mode_e          level_q, level_n;
    logic [cdw_pkg::CNT_W-1:0]   cnt_q, cnt_n;
    cdw_pkg::cause_e             cause_q, cause_n;
    logic                        drain_q, drain_n;

    logic last_lvl;
    logic dc_full;
    logic r_fire;
    logic beat_fail;

    assign last_lvl = (level_q == cdw_pkg::DDT_1LVL);
    assign dc_full  = (cnt_q == cdw_pkg::CNT_W'(cdw_pkg::DC_WORDS));

    // Bus handshake side
    assign ar_valid_o = (state_q == MEM_ACCESS);
    assign ar_burst_o = last_lvl;
    assign r_ready_o  = (state_q == NON_LEAF) || (state_q == LEAF && !dc_full) ||
                        (state_q == ERROR && drain_q);
    assign r_fire     = mem_rsp_i.r_valid && r_ready_o;

    // Beat info for the checker
    assign beat_o.take = r_fire && (state_q == NON_LEAF || state_q == LEAF);
    assign beat_o.leaf = (state_q == LEAF);
    assign beat_o.idx  = cnt_q[cdw_pkg::IDX_W-1:0];

    assign beat_fail = mem_rsp_i.r_err || entry_invalid_i || entry_misconf_i;

    assign busy_o  = (state_q != IDLE);
    assign level_o = level_q;
    assign cause_o = cause_q;

    always_comb begin
        state_n     = state_q;
        level_n     = level_q;
        cnt_n       = cnt_q;
        cause_n     = cause_q;
        drain_n     = drain_q;
        load_root_o = 1'b0;
        step_o      = 1'b0;
        update_o    = 1'b0;
        error_o     = 1'b0;

        case (state_q)
            IDLE: begin
                if (start_i) begin
                    load_root_o = 1'b1;
                    level_n     = ddtp_mode_i;
                    cnt_n       = '0;
                    drain_n     = 1'b0;
                    state_n     = MEM_ACCESS;
                end
            end

            MEM_ACCESS: begin
                if (mem_rsp_i.ar_ready) begin
                    state_n = last_lvl ? LEAF : NON_LEAF;
                end
            end

            NON_LEAF: begin
                if (r_fire) begin
                    if (beat_fail) begin
                        state_n = ERROR;
                        drain_n = !mem_rsp_i.r_last;
                    end else begin
                        // Descend one level and fetch the next entry
                        step_o  = 1'b1;
                        level_n = (level_q == cdw_pkg::DDT_3LVL) ? cdw_pkg::DDT_2LVL
                                                                 : cdw_pkg::DDT_1LVL;
                        state_n = MEM_ACCESS;
                    end
                end
            end

            LEAF: begin
                if (dc_full) begin
                    update_o = 1'b1;
                    state_n  = IDLE;
                end else if (r_fire) begin
                    cnt_n = cnt_q + 1'b1;
                    if (beat_fail) begin
                        state_n = ERROR;
                        drain_n = !mem_rsp_i.r_last;
                    end
                end
            end

            ERROR: begin
                if (!drain_q) begin
                    error_o = 1'b1;
                    state_n = IDLE;
                end else if (r_fire && mem_rsp_i.r_last) begin
                    drain_n = 1'b0;
                end
            end

            default: begin
                state_n = IDLE;
            end
        endcase

        // Bus error wins over the entry checks
        if (beat_o.take && beat_fail) begin
            if (mem_rsp_i.r_err) begin
                cause_n = cdw_pkg::CAUSE_DDT_CORRUPT;
            end else if (entry_invalid_i) begin
                cause_n = cdw_pkg::CAUSE_DDT_INVALID;
            end else begin
                cause_n = cdw_pkg::CAUSE_DDT_MISCONF;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            level_q <= cdw_pkg::DDT_1LVL;
            cnt_q   <= '0;
            cause_q <= cdw_pkg::CAUSE_DDT_INVALID;
            drain_q <= 1'b0;
        end else begin
            state_q <= state_n;
            level_q <= level_n;
            cnt_q   <= cnt_n;
            cause_q <= cause_n;
            drain_q <= drain_n;
        end
    end

endmodule

//--- cdw_ptr_gen.sv
`timescale 1ns/1ps
// Walker address generator
module cdw_ptr_gen (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        load_root_i,
    input  logic                        step_i,
    input  logic [cdw_pkg::DID_W-1:0]   did_i,
    input  logic [cdw_pkg::PPN_W-1:0]   ddtp_ppn_i,
    input  cdw_pkg::ddt_mode_e          ddtp_mode_i,
    input  cdw_pkg::ddt_mode_e          level_i,
    input  logic [cdw_pkg::DW_W-1:0]    r_data_i,
    output logic [cdw_pkg::PLEN-1:0]    ar_addr_o,
    output logic [cdw_pkg::DID_W-1:0]   up_did_o
);

    logic [cdw_pkg::DID_W-1:0] did_q;
    logic [cdw_pkg::PLEN-1:0]  addr_q;
    logic [cdw_pkg::PPN_W-1:0] nl_ppn;

    assign nl_ppn = r_data_i[cdw_pkg::NL_PPN_MSB:cdw_pkg::NL_PPN_LSB];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            did_q  <= '0;
            addr_q <= '0;
        end else if (load_root_i) begin
            did_q <= did_i;
            // Root table indexed by the top segment for the mode
            case (ddtp_mode_i)
                cdw_pkg::DDT_3LVL: addr_q <= {ddtp_ppn_i, 1'b0, did_i[23:16], 3'b000};
                cdw_pkg::DDT_2LVL: addr_q <= {ddtp_ppn_i, did_i[15:7], 3'b000};
                default:           addr_q <= {ddtp_ppn_i, did_i[6:0], 5'b00000};
            endcase
        end else if (step_i) begin
            // Next level comes from the entry just read
            if (level_i == cdw_pkg::DDT_3LVL) begin
                addr_q <= {nl_ppn, did_q[15:7], 3'b000};
            end else begin
                addr_q <= {nl_ppn, did_q[6:0], 5'b00000};
            end
        end
    end

    assign ar_addr_o = addr_q;
    assign up_did_o  = did_q;

endmodule

//--- cdw_entry_check.sv
`timescale 1ns/1ps
// Directory entry and context checks
module cdw_entry_check (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  cdw_pkg::beat_t              beat_i,
    input  logic [cdw_pkg::DW_W-1:0]    r_data_i,
    input  cdw_pkg::caps_t              caps_i,
    output logic                        entry_invalid_o,
    output logic                        entry_misconf_o,
    output cdw_pkg::dc_t                dc_o
);

    cdw_pkg::dc_t                dc_q;
    logic [cdw_pkg::MODE_W-1:0]  mode;
    logic                        t2gpa;
    logic                        mode_bare;

    assign mode      = r_data_i[cdw_pkg::MODE_LSB +: cdw_pkg::MODE_W];
    assign mode_bare = (mode == cdw_pkg::MODE_BARE);
    assign t2gpa     = r_data_i[cdw_pkg::TC_T2GPA_BIT];

    always_comb begin
        entry_invalid_o = 1'b0;
        entry_misconf_o = 1'b0;

        if (beat_i.take) begin
            if (!beat_i.leaf) begin
                entry_invalid_o = !r_data_i[cdw_pkg::NL_V_BIT];
                entry_misconf_o = |(r_data_i & cdw_pkg::NL_RSVD_MASK);
            end else begin
                case (beat_i.idx)
                    cdw_pkg::DC_TC: begin
                        entry_invalid_o = !r_data_i[cdw_pkg::TC_V_BIT];
                        entry_misconf_o = |(r_data_i & cdw_pkg::TC_RSVD_MASK) ||
                                          (t2gpa && !r_data_i[cdw_pkg::TC_EN_ATS_BIT]) ||
                                          (t2gpa && !caps_i.t2gpa);
                    end

                    cdw_pkg::DC_IOHGATP: begin
                        // G-stage needs bare or a supported x4 mode
                        entry_misconf_o = !(mode_bare ||
                                            (mode == cdw_pkg::MODE_SV39 && caps_i.svx4) ||
                                            (mode == cdw_pkg::MODE_SV48 && caps_i.svx4)) ||
                                          (dc_q.tc[cdw_pkg::TC_T2GPA_BIT] && mode_bare);
                    end

                    cdw_pkg::DC_TA: begin
                        entry_misconf_o = |(r_data_i & cdw_pkg::TA_RSVD_MASK);
                    end

                    default: begin
                        entry_misconf_o = !(mode_bare ||
                                            (mode == cdw_pkg::MODE_SV39 && caps_i.sv39) ||
                                            (mode == cdw_pkg::MODE_SV48 && caps_i.sv48));
                    end
                endcase
            end
        end
    end

    // Context words land in order of arrival
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dc_q <= '0;
        end else if (beat_i.take && beat_i.leaf) begin
            case (beat_i.idx)
                cdw_pkg::DC_TC:      dc_q.tc      <= r_data_i;
                cdw_pkg::DC_IOHGATP: dc_q.iohgatp <= r_data_i;
                cdw_pkg::DC_TA:      dc_q.ta      <= r_data_i;
                default:             dc_q.fsc     <= r_data_i;
            endcase
        end
    end

    assign dc_o = dc_q;

endmodule

//--- cdw_top.sv
`timescale 1ns/1ps
// Context directory walker top
module cdw_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        start_i,
    input  logic [cdw_pkg::DID_W-1:0]   did_i,
    input  logic [cdw_pkg::PPN_W-1:0]   ddtp_ppn_i,
    input  cdw_pkg::ddt_mode_e          ddtp_mode_i,
    input  cdw_pkg::caps_t              caps_i,
    input  cdw_pkg::mem_rsp_t           mem_rsp_i,
    output cdw_pkg::mem_req_t           mem_req_o,
    output logic                        busy_o,
    output logic                        update_o,
    output logic [cdw_pkg::DID_W-1:0]   up_did_o,
    output cdw_pkg::dc_t                up_dc_o,
    output logic                        error_o,
    output cdw_pkg::cause_e             cause_o
);

    cdw_pkg::beat_t      beat;
    cdw_pkg::ddt_mode_e  level;
    logic                load_root;
    logic                step;
    logic                entry_invalid;
    logic                entry_misconf;

    cdw_ctrl u_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .start_i         (start_i),
        .ddtp_mode_i     (ddtp_mode_i),
        .mem_rsp_i       (mem_rsp_i),
        .entry_invalid_i (entry_invalid),
        .entry_misconf_i (entry_misconf),
        .ar_valid_o      (mem_req_o.ar_valid),
        .ar_burst_o      (mem_req_o.ar_burst),
        .r_ready_o       (mem_req_o.r_ready),
        .busy_o          (busy_o),
        .load_root_o     (load_root),
        .step_o          (step),
        .level_o         (level),
        .beat_o          (beat),
        .update_o        (update_o),
        .error_o         (error_o),
        .cause_o         (cause_o)
    );

    cdw_ptr_gen u_ptr_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_root_i (load_root),
        .step_i      (step),
        .did_i       (did_i),
        .ddtp_ppn_i  (ddtp_ppn_i),
        .ddtp_mode_i (ddtp_mode_i),
        .level_i     (level),
        .r_data_i    (mem_rsp_i.r_data),
        .ar_addr_o   (mem_req_o.ar_addr),
        .up_did_o    (up_did_o)
    );

    cdw_entry_check u_entry_check (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .beat_i          (beat),
        .r_data_i        (mem_rsp_i.r_data),
        .caps_i          (caps_i),
        .entry_invalid_o (entry_invalid),
        .entry_misconf_o (entry_misconf),
        .dc_o            (up_dc_o)
    );

endmodule

//--- tb_cdw_monitor.sv
`timescale 1ns/1ps
// Walker result monitor
module tb_cdw_monitor (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      arm_i,
    input  logic                      report_i,
    input  cdw_pkg::mem_req_t         req_i,
    input  cdw_pkg::mem_rsp_t         rsp_i,
    input  logic                      busy_i,
    input  logic                      update_i,
    input  logic                      error_i,
    input  logic [11:0]               cause_i,
    input  logic [23:0]               up_did_i,
    input  cdw_pkg::dc_t              up_dc_i,
    input  int                        exp_n_i,
    input  logic [3:0][55:0]          exp_addr_i,
    input  logic                      exp_err_i,
    input  logic [11:0]               exp_cause_i,
    input  logic [23:0]               exp_did_i,
    input  cdw_pkg::dc_t              exp_dc_i,
    output logic                      done_o,
    output int                        errors_o,
    output int                        tests_o
);

    logic armed;
    logic exp_busy;
    int   n_seen;
    int   owed;
    int   test_errs;

    task automatic note_error(input string msg);
        $display("%s", msg);
        errors_o++;
        test_errs++;
    endtask

    task automatic close_test();
        if (n_seen != exp_n_i) begin
            note_error($sformatf("Walk ended after %0d requests instead of %0d",
                                 n_seen, exp_n_i));
        end
        if (error_i != exp_err_i) begin
            note_error($sformatf("** Error: error_o got %h exp %h", error_i, exp_err_i));
        end else if (exp_err_i) begin
            if (cause_i != exp_cause_i) begin
                note_error($sformatf("** Error: cause_o got %h exp %h", cause_i, exp_cause_i));
            end
        end else begin
            if (up_did_i != exp_did_i) begin
                note_error($sformatf("** Error: up_did_o got %h exp %h", up_did_i, exp_did_i));
            end
            if (up_dc_i != exp_dc_i) begin
                note_error($sformatf("** Error: up_dc_o got %h exp %h", up_dc_i, exp_dc_i));
            end
        end
        // Every beat of the last burst must be taken first
        if (owed != 0) begin
            note_error($sformatf("Walk ended with %0d beats not accepted", owed));
        end
        $display("test %0d: %s", tests_o, (test_errs == 0) ? "pass" : "FAIL");
        tests_o++;
        armed  = 1'b0;
        done_o = 1'b1;
    endtask

    initial begin
        done_o    = 1'b0;
        errors_o  = 0;
        tests_o   = 0;
        armed     = 1'b0;
        exp_busy  = 1'b0;
        n_seen    = 0;
        owed      = 0;
        test_errs = 0;
    end

    // Mid-cycle sampling, all inputs settled
    always @(negedge clk_i) begin
        if (!rst_ni) begin
            if (busy_i || update_i || error_i || req_i.ar_valid || req_i.r_ready) begin
                note_error("DUT outputs not idle during reset");
            end
            owed = 0;
        end else begin
            if (arm_i) begin
                armed     = 1'b1;
                done_o    = 1'b0;
                n_seen    = 0;
                owed      = 0;
                test_errs = 0;
            end
            // Busy from the cycle after start through the end pulse
            exp_busy = armed && !arm_i;
            if (busy_i != exp_busy) begin
                note_error($sformatf("** Error: busy_o got %h exp %h",
                                     busy_i, exp_busy));
            end
            if (req_i.ar_valid && rsp_i.ar_ready) begin
                if (!armed || n_seen >= exp_n_i) begin
                    note_error($sformatf("Unexpected request to %h", req_i.ar_addr));
                end else if (req_i.ar_addr != exp_addr_i[n_seen]) begin
                    note_error($sformatf("** Error: ar_addr got %h exp %h",
                                         req_i.ar_addr, exp_addr_i[n_seen]));
                end
                n_seen++;
                owed += req_i.ar_burst ? 4 : 1;
            end
            if (rsp_i.r_valid && req_i.r_ready) begin
                owed--;
            end
            if (update_i || error_i) begin
                if (!armed) begin
                    note_error("End pulse outside a walk");
                end else begin
                    close_test();
                end
            end
        end
    end

    always @(posedge report_i) begin
        $display("tests %0d, errors %0d", tests_o, errors_o);
    end

endmodule

//--- tb_cdw.sv
`timescale 1ns/1ps
// Walker testbench top
module tb_cdw;

    localparam int N_TESTS = 60;

    logic                clk_i;
    logic                rst_ni;
    logic                start_i;
    logic [23:0]         did_i;
    logic [43:0]         ddtp_ppn_i;
    cdw_pkg::ddt_mode_e  ddtp_mode_i;
    cdw_pkg::caps_t      caps_i;
    cdw_pkg::mem_rsp_t   mem_rsp_i;
    cdw_pkg::mem_req_t   mem_req_o;
    logic                busy_o;
    logic                update_o;
    logic [23:0]         up_did_o;
    cdw_pkg::dc_t        up_dc_o;
    logic                error_o;
    cdw_pkg::cause_e     cause_o;

    logic                arm;
    logic                report;
    int                  exp_n;
    logic [3:0][55:0]    exp_addr;
    logic                exp_err;
    logic [11:0]         exp_cause;
    logic [23:0]         exp_did;
    cdw_pkg::dc_t        exp_dc;
    logic                done;
    int                  errors;
    int                  tests;

    logic [31:0]         seed;
    logic [31:0]         stall_seed;
    logic                stall_en;
    logic                dbl_start;
    logic                err_en;
    logic [55:0]         err_addr;
    logic [63:0]         mem [logic [55:0]];

    logic                serving;
    logic [55:0]         rd_addr;
    int                  beat;
    int                  nbeats;

    cdw_top dut0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (start_i),
        .did_i       (did_i),
        .ddtp_ppn_i  (ddtp_ppn_i),
        .ddtp_mode_i (ddtp_mode_i),
        .caps_i      (caps_i),
        .mem_rsp_i   (mem_rsp_i),
        .mem_req_o   (mem_req_o),
        .busy_o      (busy_o),
        .update_o    (update_o),
        .up_did_o    (up_did_o),
        .up_dc_o     (up_dc_o),
        .error_o     (error_o),
        .cause_o     (cause_o)
    );

    tb_cdw_monitor mon0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .arm_i       (arm),
        .report_i    (report),
        .req_i       (mem_req_o),
        .rsp_i       (mem_rsp_i),
        .busy_i      (busy_o),
        .update_i    (update_o),
        .error_i     (error_o),
        .cause_i     (cause_o),
        .up_did_i    (up_did_o),
        .up_dc_i     (up_dc_o),
        .exp_n_i     (exp_n),
        .exp_addr_i  (exp_addr),
        .exp_err_i   (exp_err),
        .exp_cause_i (exp_cause),
        .exp_did_i   (exp_did),
        .exp_dc_i    (exp_dc),
        .done_o      (done),
        .errors_o    (errors),
        .tests_o     (tests)
    );

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] rnd();
        seed = xorshift(seed);
        return seed;
    endfunction

    // Unwritten memory returns a pattern of the full address
    function automatic logic [63:0] rd(input logic [55:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a[31:0] ^ 32'h5a5a_0f0f, a[55:24]};
    endfunction

    function automatic logic [55:0] nl_addr(input logic [43:0] p, input int lvl);
        if (lvl == 2) begin
            return {p, 1'b0, did_i[23:16], 3'd0};
        end
        return {p, did_i[15:7], 3'd0};
    endfunction

    // Context word rules, 0 when the word is legal
    function automatic logic [11:0] ctx_cause(input int i, input logic [63:0] w,
                                              input logic [63:0] tc, input cdw_pkg::caps_t c);
        logic [3:0] m;
        m = w[63:60];
        case (i)
            0: begin
                if (!w[0]) return 12'd258;
                if (|w[63:32] || (w[2] && (!w[1] || !c.t2gpa))) return 12'd259;
            end
            1: begin
                if (!(m == 4'd0 || ((m == 4'd8 || m == 4'd9) && c.svx4))) return 12'd259;
                if (tc[2] && m == 4'd0) return 12'd259;
            end
            2: begin
                if (|w[11:0] || |w[63:52]) return 12'd259;
            end
            default: begin
                if (!(m == 4'd0 || (m == 4'd8 && c.sv39) || (m == 4'd9 && c.sv48))) begin
                    return 12'd259;
                end
            end
        endcase
        return 12'd0;
    endfunction

    task automatic build_test();
        logic [31:0] r;
        logic [43:0] ppn;
        logic [43:0] nxt;
        logic [55:0] a;
        logic [55:0] nl [0:1];
        logic [63:0] w [0:3];
        logic [63:0] tmp;
        logic [3:0]  m;
        int          nnl;
        int          kind;
        int          k;
        mem.delete();
        r = rnd();
        did_i = r[23:0];
        r = rnd();
        ddtp_mode_i = cdw_pkg::ddt_mode_e'(2'(r % 32'd3));
        caps_i      = cdw_pkg::caps_t'(r[7:4]);
        stall_en    = r[8];
        dbl_start   = r[9];
        kind        = int'(r[14:12]);
        r = rnd();
        ppn[43:32] = r[11:0];
        r = rnd();
        ppn[31:0]  = r;
        ddtp_ppn_i = ppn;
        nnl = 0;
        for (int lvl = int'(ddtp_mode_i); lvl > 0; lvl--) begin
            a = nl_addr(ppn, lvl);
            r = rnd();
            nxt[43:32] = r[11:0];
            r = rnd();
            nxt[31:0] = r;
            mem[a] = {10'd0, nxt, 9'd0, 1'b1};
            nl[nnl] = a;
            nnl++;
            ppn = nxt;
        end
        a = {ppn, did_i[6:0], 5'd0};
        r = rnd();
        m = caps_i.svx4 ? (r[0] ? 4'd9 : 4'd8) : 4'd0;
        w[1] = {m, r[27:0], r};
        w[0] = {32'd0, r[31:3], r[1] & r[2] & caps_i.t2gpa & (m != 4'd0), r[1], 1'b1};
        w[2] = {12'd0, r[7:0], r, 12'd0};
        r = rnd();
        m = (r[0] && caps_i.sv39) ? 4'd8 : ((r[1] && caps_i.sv48) ? 4'd9 : 4'd0);
        w[3] = {m, r[27:0], r};
        err_en   = 1'b0;
        err_addr = '1;
        r = rnd();
        // Directory faults fall back to a context fault in 1-level mode
        if ((kind == 4 || kind == 5) && nnl > 0) begin
            k   = (nnl == 2) ? int'(r[0]) : 0;
            tmp = mem[nl[k]];
            if (kind == 4) begin
                tmp[0] = 1'b0;
            end else begin
                tmp[r[1] ? int'(r[15:8] % 8'd9) + 1 : int'(r[15:8] % 8'd10) + 54] = 1'b1;
            end
            mem[nl[k]] = tmp;
        end else if (kind >= 4 && kind <= 6) begin
            case (r[3:2])
                2'd0: begin
                    if (r[4]) w[0][0] = 1'b0;
                    else w[0][40] = 1'b1;
                end
                2'd1: w[1][63:60] = 4'd5;
                2'd2: w[2][0] = 1'b1;
                default: w[3][63:60] = 4'd5;
            endcase
        end else if (kind == 7) begin
            err_en = 1'b1;
            k = int'(r % 32'(nnl + 4));
            err_addr = (k < nnl) ? nl[k] : a + 56'(8 * (k - nnl));
        end
        for (int i = 0; i < 4; i++) begin
            mem[a + 56'(8 * i)] = w[i];
        end
    endtask

    // Reference walk over the memory contents
    task automatic compute_expected();
        logic [43:0] ppn;
        logic [55:0] a;
        logic [63:0] w;
        logic [11:0] c;
        int          lvl;
        ppn       = ddtp_ppn_i;
        lvl       = int'(ddtp_mode_i);
        exp_n     = 0;
        exp_err   = 1'b0;
        exp_cause = '0;
        exp_did   = did_i;
        exp_dc    = '0;
        exp_addr  = '0;
        while (lvl > 0) begin
            a = nl_addr(ppn, lvl);
            exp_addr[exp_n] = a;
            exp_n++;
            w = rd(a);
            if (err_en && a == err_addr) c = 12'd268;
            else if (!w[0]) c = 12'd258;
            else if (|w[9:1] || |w[63:54]) c = 12'd259;
            else c = 12'd0;
            if (c != 12'd0) begin
                exp_err   = 1'b1;
                exp_cause = c;
                return;
            end
            ppn = w[53:10];
            lvl--;
        end
        a = {ppn, did_i[6:0], 5'd0};
        exp_addr[exp_n] = a;
        exp_n++;
        for (int i = 0; i < 4; i++) begin
            w = rd(a + 56'(8 * i));
            if (err_en && a + 56'(8 * i) == err_addr) c = 12'd268;
            else c = ctx_cause(i, w, exp_dc.tc, caps_i);
            if (c != 12'd0) begin
                exp_err   = 1'b1;
                exp_cause = c;
                return;
            end
            case (i)
                0: exp_dc.tc = w;
                1: exp_dc.iohgatp = w;
                2: exp_dc.ta = w;
                default: exp_dc.fsc = w;
            endcase
        end
    endtask

    // Memory model with random stalls
    initial begin
        mem_rsp_i  = '0;
        serving    = 1'b0;
        rd_addr    = '0;
        beat       = 0;
        nbeats     = 1;
        stall_seed = 32'h4c32 ^ 32'h9e37_79b9;
        forever begin
            @(posedge clk_i);
            #1;
            stall_seed = xorshift(stall_seed);
            mem_rsp_i.ar_ready = rst_ni && !serving && (!stall_en || stall_seed[1:0] != 2'd0);
            mem_rsp_i.r_valid  = serving && (!stall_en || stall_seed[3:2] != 2'd0);
            mem_rsp_i.r_data   = rd(rd_addr + 56'(8 * beat));
            mem_rsp_i.r_last   = (beat == nbeats - 1);
            mem_rsp_i.r_err    = err_en && (rd_addr + 56'(8 * beat) == err_addr);
            @(negedge clk_i);
            if (!serving && mem_req_o.ar_valid && mem_rsp_i.ar_ready) begin
                serving = 1'b1;
                rd_addr = mem_req_o.ar_addr;
                nbeats  = mem_req_o.ar_burst ? 4 : 1;
                beat    = 0;
            end else if (serving && mem_rsp_i.r_valid && mem_req_o.r_ready) begin
                beat++;
                if (beat == nbeats) serving = 1'b0;
            end
        end
    end

    initial begin
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        start_i     = 1'b0;
        did_i       = '0;
        ddtp_ppn_i  = '0;
        ddtp_mode_i = cdw_pkg::DDT_1LVL;
        caps_i      = '0;
        arm         = 1'b0;
        report      = 1'b0;
        stall_en    = 1'b0;
        err_en      = 1'b0;
        err_addr    = '1;
        seed        = 32'h4c32;
        compute_expected();
        repeat (4) @(posedge clk_i);
        #1 rst_ni = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            @(posedge clk_i);
            #1;
            build_test();
            compute_expected();
            arm     = 1'b1;
            start_i = 1'b1;
            @(posedge clk_i);
            #1;
            arm     = 1'b0;
            start_i = 1'b0;
            if (dbl_start) begin
                // A second strobe while busy must be ignored
                start_i = 1'b1;
                did_i   = ~did_i;
                @(posedge clk_i);
                #1 start_i = 1'b0;
            end
            while (!done) @(posedge clk_i);
            repeat (3) @(posedge clk_i);
        end
        report = 1'b1;
        #1;
        if (errors == 0 && tests == N_TESTS) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from the test count
    initial begin
        #(N_TESTS * 200 * 4 + 4 * 4);
        $display("Timeout: walks did not finish in time");
        $display("Checks failed");
        $finish;
    end

endmodule

//--- sources.f
cdw_pkg.sv
cdw_ctrl.sv
cdw_ptr_gen.sv
cdw_entry_check.sv
cdw_top.sv
tb_cdw_monitor.sv
tb_cdw.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_cdw -f sources.f -o sim_cdw

./obj_dir/sim_cdw > sim.log
cat sim.log

grep -q "^All checks passed$" sim.log
